// File: src/fetch_pkg.sv
package fetch_pkg;

  ////////////////////////////////////////
  // Fetch geometry
  ////////////////////////////////////////

  localparam int block_bytes = 8;  // One fetch block, four halfwords

  ////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;  // Block aligned
  } fetch_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [63:0] data;  // Halfword k in bits 16k+15:16k
  } fetch_rsp_t;

  // Branch target, any halfword address
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } redirect_t;

  ////////////////////////////////////////
  // Issue side
  ////////////////////////////////////////

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;  // Upper half zero for 16-bit instructions
  } slot_t;

  typedef struct packed {
    slot_t slot0;  // Older of the two
    slot_t slot1;
  } issue_t;

endpackage

// File: src/fetch_pc_gen.sv
`timescale 1ns/1ns

module fetch_pc_gen (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::redirect_t  redirect,
  input  logic                  full,
  output fetch_pkg::fetch_req_t fetch_req
);
  import fetch_pkg::*;

  localparam logic [31:0] block_step = 32'(block_bytes);
  localparam logic [31:0] block_mask = ~(block_step - 32'd1);

  logic        active;        // Set by the first redirect
  logic [31:0] next_addr;
  logic [31:0] target_block;

  assign target_block = redirect.pc & block_mask;

  // The redirect block is always requested since clear empties the buffer
  always_comb begin
    fetch_req.valid = redirect.valid | (active & ~full);
    fetch_req.addr  = redirect.valid ? target_block : next_addr;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      active    <= 1'b0;
      next_addr <= '0;
    end else if (redirect.valid) begin
      active    <= 1'b1;
      next_addr <= target_block + block_step;
    end else if (fetch_req.valid) begin
      next_addr <= next_addr + block_step;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_req_aligned: assert property (@(posedge clock) disable iff (!reset)
    fetch_req.valid |-> (fetch_req.addr & ~block_mask) == '0)
    else $error("fetch request at unaligned address %h", fetch_req.addr);

endmodule

// File: src/fetch_buffer.sv
`timescale 1ns/1ns

module fetch_buffer #(
  parameter int buffer_depth = 16
) (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::redirect_t  redirect,
  input  fetch_pkg::fetch_rsp_t fetch_rsp,
  input  logic                  issue_stall,
  output fetch_pkg::issue_t     issue,
  output logic                  full
);
  import fetch_pkg::*;

  localparam int idx_w      = $clog2(buffer_depth);
  localparam int cnt_w      = idx_w + 1;
  localparam int blk_halves = block_bytes / 2;
  localparam int look_len   = 4;  // Enough for two 32-bit instructions

  localparam logic [cnt_w-1:0] blk_count = cnt_w'(blk_halves);
  localparam logic [cnt_w-1:0] high_mark = cnt_w'(buffer_depth - blk_halves);
  localparam logic [cnt_w-1:0] one_half  = cnt_w'(1);
  localparam logic [cnt_w-1:0] two_half  = cnt_w'(2);

  typedef struct packed {
    logic [31:0] addr;
    logic [15:0] half;
  } entry_t;

  entry_t ring [buffer_depth];

  logic [idx_w-1:0] wr_idx;
  logic [idx_w-1:0] rd_idx;
  logic [cnt_w-1:0] count;   // Halfwords held from rd_idx on
  logic [1:0]       align;   // Leading halfwords to skip after a redirect

  logic             wr_en;
  entry_t           in_blk [blk_halves];
  entry_t           look [look_len];
  logic [cnt_w-1:0] avail;
  logic [cnt_w-1:0] len0;
  logic [cnt_w-1:0] len1;
  logic [cnt_w-1:0] used;
  logic             take0;
  logic             take1;
  logic             pending;
  logic [cnt_w-1:0] count_next;
  logic             full_next;

  ////////////////////////////////////////
  // Clear, write, lookahead and decode
  ////////////////////////////////////////

  always_comb begin
    logic [idx_w-1:0] idx;
    logic [idx_w-1:0] off;
    logic [1:0]       pos1;

    wr_en = fetch_rsp.valid && !redirect.valid;  // Clear drops a stale response
    for (int j = 0; j < blk_halves; j++) begin
      in_blk[j].addr = fetch_rsp.addr + 32'(2 * j);
      in_blk[j].half = fetch_rsp.data[16*j +: 16];
    end

    if (redirect.valid) begin
      avail = '0;
    end else if (wr_en) begin
      avail = count + blk_count - cnt_w'(align);
    end else begin
      avail = count;
    end

    // Halfwords being written this cycle bypass the ring
    for (int k = 0; k < look_len; k++) begin
      idx = rd_idx + idx_w'(k);
      off = idx - wr_idx;
      if (wr_en && off < idx_w'(blk_halves)) begin
        look[k] = in_blk[off[1:0]];
      end else begin
        look[k] = ring[idx];
      end
    end

    len0 = (&look[0].half[1:0]) ? two_half : one_half;
    pos1 = len0[1:0];
    len1 = (&look[pos1].half[1:0]) ? two_half : one_half;

    take0 = 1'b0;
    take1 = 1'b0;
    if (!issue_stall && avail != '0) begin
      take0 = (avail >= len0);  // Never half of a 32-bit instruction
      if (take0 && avail > len0) begin
        take1 = (avail >= len0 + len1);
      end
    end

    used = (take0 ? len0 : '0) + (take1 ? len1 : '0);

    issue.slot0.valid = take0;
    issue.slot0.pc    = take0 ? look[0].addr : '1;
    issue.slot0.instr = '0;
    if (take0) begin
      issue.slot0.instr = (len0 == two_half) ? {look[1].half, look[0].half}
                                             : {16'h0000, look[0].half};
    end

    issue.slot1.valid = take1;
    issue.slot1.pc    = take1 ? look[pos1].addr : '1;
    issue.slot1.instr = '0;
    if (take1) begin
      issue.slot1.instr = (len1 == two_half) ? {look[pos1 + 2'd1].half, look[pos1].half}
                                             : {16'h0000, look[pos1].half};
    end

    // Counts the block still in flight so its response always fits
    count_next = avail - used;
    pending    = redirect.valid || !full;
    full_next  = (count_next + (pending ? blk_count : '0)) > high_mark;
  end

  ////////////////////////////////////////
  // State
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (wr_en) begin
      for (int j = 0; j < blk_halves; j++) begin
        ring[wr_idx + idx_w'(j)] <= in_blk[j];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_idx <= '0;
      rd_idx <= '0;
      count  <= '0;
      align  <= '0;
      full   <= 1'b0;
    end else begin
      if (redirect.valid) begin
        wr_idx <= '0;
        rd_idx <= idx_w'(redirect.pc[2:1]);
        align  <= redirect.pc[2:1];
      end else begin
        if (wr_en) begin
          wr_idx <= wr_idx + idx_w'(blk_halves);
          align  <= '0;  // Skip is folded into count
        end
        rd_idx <= rd_idx + used[idx_w-1:0];
      end
      count <= count_next;
      full  <= full_next;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_count_bound: assert property (@(posedge clock) disable iff (!reset)
    count <= cnt_w'(buffer_depth))
    else $error("buffer count %0d over depth", count);

  // Relies on the PC generator holding requests while full
  a_rsp_room: assert property (@(posedge clock) disable iff (!reset)
    wr_en |-> count <= high_mark)
    else $error("fetch response arrived with no room, count %0d", count);

endmodule

// File: src/fetch_frontend.sv
`timescale 1ns/1ns

module fetch_frontend #(
  parameter int buffer_depth = 16
) (
  input  logic                  clock,
  input  logic                  reset,
  input  fetch_pkg::redirect_t  redirect,
  input  fetch_pkg::fetch_rsp_t fetch_rsp,
  input  logic                  issue_stall,
  output fetch_pkg::fetch_req_t fetch_req,
  output fetch_pkg::issue_t     issue
);

  logic full;  // Buffer stall level

  ////////////////////////////////////////
  // Fetch address
  ////////////////////////////////////////

  fetch_pc_gen pc_gen_i (
    .clock     (clock),
    .reset     (reset),
    .redirect  (redirect),
    .full      (full),
    .fetch_req (fetch_req)
  );

  ////////////////////////////////////////
  // Halfword buffer and alignment
  ////////////////////////////////////////

  fetch_buffer #(
    .buffer_depth (buffer_depth)
  ) buffer_i (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .fetch_rsp   (fetch_rsp),
    .issue_stall (issue_stall),
    .issue       (issue),
    .full        (full)
  );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int period       = 4,
  parameter int reset_cycles = 3
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // Active low, released just after an edge
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    #1 reset = 1'b1;
  end

endmodule

// File: verif/tb_checker.sv
`timescale 1ns/1ns

module tb_checker #(
  parameter int image_halves = 1024
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [16*image_halves-1:0] image,
  input  fetch_pkg::redirect_t       redirect,
  input  logic                       issue_stall,
  input  fetch_pkg::fetch_req_t      fetch_req,
  input  fetch_pkg::issue_t          issue,
  input  logic                       done,
  output int                         error_count
);
  import fetch_pkg::*;

  int          errors = 0;
  int          checks = 0;
  logic [31:0] exp_pc;
  logic [31:0] target_pc;
  logic        started;    // First redirect seen
  logic        got_first;
  logic        closed;
  logic        hold_seen;
  int          since;      // Cycles since the last redirect
  int          first_due;
  int          stall_run;
  int          quiet_run;  // Stalled cycles with no fetch request
  int          idle_run;   // Unstalled cycles with nothing issued

  assign error_count = errors;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [31:0] next_instr(input logic [31:0] pc,
                                             input logic [16*image_halves-1:0] img,
                                             output int len);
    int          idx;
    logic [15:0] lo;
    logic [15:0] hi;
    idx = int'((pc >> 1) % image_halves);
    lo  = img[16*idx +: 16];
    hi  = img[16*((idx + 1) % image_halves) +: 16];
    if (lo[1:0] == 2'b11) begin  // 32-bit instruction
      len = 4;
      return {hi, lo};
    end
    len = 2;
    return {16'h0000, lo};
  endfunction

  task automatic report(input string msg);
    errors++;
    $display("%s at %0t", msg, $time);
  endtask

  task automatic check_slot(input slot_t s, input string name);
    logic [31:0] exp_instr;
    int          len;
    exp_instr = next_instr(exp_pc, image, len);
    checks++;
    if (s.pc !== exp_pc || s.instr !== exp_instr) begin
      errors++;
      $display("FAIL @%0t: %s pc %h instr %h, expected pc %h instr %h",
               $time, name, s.pc, s.instr, exp_pc, exp_instr);
    end
    exp_pc = exp_pc + 32'(len);
  endtask

  // Empty slots show pc all ones and instr zero
  task automatic check_empty_slot(input slot_t s, input string name);
    if (!s.valid && (s.pc !== '1 || s.instr !== '0)) begin
      errors++;
      $display("FAIL @%0t: invalid %s shows pc %h instr %h, expected pc %h instr %h",
               $time, name, s.pc, s.instr, 32'hffff_ffff, 32'h0000_0000);
    end
  endtask

  ////////////////////////////////////////
  // Compare at the falling edge
  ////////////////////////////////////////

  always @(negedge clock) begin
    int len;
    if (done) begin
      if (!closed) begin
        closed = 1'b1;
        if (!hold_seen) report("Long issue stall hold was never observed");
        $display("Checker: %0d instructions compared, %0d errors", checks, errors);
      end
    end else if (!reset) begin
      started   = 1'b0;
      closed    = 1'b0;
      hold_seen = 1'b0;
      stall_run = 0;
      quiet_run = 0;
      idle_run  = 0;
    end else if (redirect.valid) begin
      if (issue.slot0.valid || issue.slot1.valid) begin
        report("Instruction issued in a redirect cycle");
      end
      void'(next_instr(redirect.pc, image, len));
      // A 32-bit instruction in the last halfword needs the next block
      first_due = (redirect.pc[2:1] == 2'd3 && len == 4) ? 2 : 1;
      exp_pc    = redirect.pc;
      target_pc = redirect.pc;
      started   = 1'b1;
      got_first = 1'b0;
      since     = 0;
      idle_run  = 0;
    end else if (!started) begin
      if (fetch_req.valid || issue.slot0.valid || issue.slot1.valid) begin
        report("Fetch or issue active before the first redirect");
      end
    end else begin
      since++;
      if (issue_stall && (issue.slot0.valid || issue.slot1.valid)) begin
        report("Instruction issued while issue_stall was high");
      end
      if (issue.slot1.valid && !issue.slot0.valid) begin
        report("Slot1 valid without slot0");
      end
      if (issue.slot0.valid) check_slot(issue.slot0, "slot0");
      if (issue.slot1.valid) check_slot(issue.slot1, "slot1");
      check_empty_slot(issue.slot0, "slot0");
      check_empty_slot(issue.slot1, "slot1");
      if (issue.slot0.valid) got_first = 1'b1;
      if (since == first_due && !got_first && !issue_stall) begin
        $display("No instruction issued on time after the redirect to %h", target_pc);
        report("Late first issue after redirect");
      end

      idle_run = (!issue_stall && !issue.slot0.valid) ? idle_run + 1 : 0;
      if (idle_run == 4) report("Issue stopped while issue_stall was low");

      stall_run = issue_stall ? stall_run + 1 : 0;
      quiet_run = (issue_stall && !fetch_req.valid) ? quiet_run + 1 : 0;
      if (stall_run == 25) begin  // Only the long hold gets here
        hold_seen = 1'b1;
        if (quiet_run < 10) report("Fetch requests kept going during the long issue stall");
      end
    end
  end

endmodule

// File: verif/tb_frontend.sv
`timescale 1ns/1ns

module tb_frontend;
  import fetch_pkg::*;

  localparam int image_halves = 1024;
  localparam int cycle_limit  = 3000;  // About twice the test length

  logic                       clock;
  logic                       reset;
  redirect_t                  redirect;
  fetch_rsp_t                 fetch_rsp;
  fetch_req_t                 fetch_req;
  fetch_req_t                 req_seen;
  issue_t                     issue;
  logic                       issue_stall;
  logic                       done;
  int                         error_count;
  int                         cycles = 0;
  int unsigned                seed;
  logic [16*image_halves-1:0] image;
  logic [31:0]                boundaries [$];  // Instruction start addresses

  tb_clock clock_i (.clock(clock), .reset(reset));

  fetch_frontend #(.buffer_depth(16)) dut_i (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .fetch_rsp   (fetch_rsp),
    .issue_stall (issue_stall),
    .fetch_req   (fetch_req),
    .issue       (issue)
  );

  tb_checker #(.image_halves(image_halves)) checker_i (
    .clock       (clock),
    .reset       (reset),
    .image       (image),
    .redirect    (redirect),
    .issue_stall (issue_stall),
    .fetch_req   (fetch_req),
    .issue       (issue),
    .done        (done),
    .error_count (error_count)
  );

  ////////////////////////////////////////
  // Program image and memory
  ////////////////////////////////////////

  task automatic fill_image();
    int          idx;
    logic [31:0] r;
    logic [31:0] r2;
    idx = 0;
    while (idx < image_halves) begin
      r  = $urandom;
      r2 = $urandom;
      boundaries.push_back(32'(2 * idx));
      if (r[31] && idx < image_halves - 1) begin
        image[16*idx +: 16]       = {r[15:2], 2'b11};
        image[16*(idx + 1) +: 16] = r2[15:0];
        idx += 2;
      end else begin
        image[16*idx +: 16] = {r[15:2], 2'(r[17:16] % 3)};  // Never 11
        idx += 1;
      end
    end
  endtask

  function automatic logic [63:0] read_block(input logic [31:0] addr);
    logic [63:0] blk;
    int          base;
    base = int'((addr >> 1) % image_halves);
    for (int k = 0; k < 4; k++) begin
      blk[16*k +: 16] = image[16*((base + k) % image_halves) +: 16];
    end
    return blk;
  endfunction

  // One cycle latency, request seen mid cycle
  initial begin
    fetch_rsp = '0;
    forever begin
      @(negedge clock);
      req_seen = fetch_req;
      @(posedge clock);
      #1;
      fetch_rsp.valid = req_seen.valid;
      fetch_rsp.addr  = req_seen.addr;
      fetch_rsp.data  = read_block(req_seen.addr);
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clock);
    #1;
  endtask

  task automatic send_redirect(input logic [31:0] pc);
    redirect.valid = 1'b1;
    redirect.pc    = pc;
    wait_cycles(1);
    redirect.valid = 1'b0;
  endtask

  function automatic logic [31:0] pick_target(input int offset);
    logic [31:0] t;
    t = boundaries[$urandom % boundaries.size()];
    while (t[2:0] != 3'(offset)) t = boundaries[$urandom % boundaries.size()];
    return t;
  endfunction

  task automatic finish_run(input logic timed_out);
    done = 1'b1;
    repeat (2) @(posedge clock);  // Checker prints its closing line
    if (timed_out || error_count != 0) begin
      $display("Errors found");
    end else begin
      $display("No errors");
    end
    $finish;
  endtask

  initial begin
    redirect    = '0;
    issue_stall = 1'b0;
    done        = 1'b0;
    seed        = 99544;
    void'($urandom(seed));
    fill_image();
    wait (reset === 1'b1);
    wait_cycles(5);  // Idle after reset
    send_redirect(32'h0);
    wait_cycles(400);
    repeat (3) begin
      for (int off = 0; off < 8; off += 2) begin
        send_redirect(pick_target(off));
        wait_cycles(40);
      end
    end
    repeat (400) begin
      issue_stall = !issue_stall && (($urandom % 4) == 0);  // Single-cycle pulses
      wait_cycles(1);
    end
    issue_stall = 1'b0;
    wait_cycles(20);
    issue_stall = 1'b1;
    wait_cycles(30);
    issue_stall = 1'b0;
    wait_cycles(300);
    finish_run(1'b0);
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run still going after %0d cycles", cycle_limit);
      finish_run(1'b1);
    end
  end

endmodule

// File: verilog.f
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_buffer.sv
src/fetch_frontend.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/tb_frontend.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - src/fetch_pkg.sv
  - src/fetch_pc_gen.sv
  - src/fetch_buffer.sv
  - src/fetch_frontend.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/tb_checker.sv
      - verif/tb_frontend.sv
